// ==== Makefile ====
TOP = alu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_alu
	@out="$$(./obj_dir/sim_alu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== bench/alu_assertions.sv ====
`timescale 1ns/1ps

module alu_assertions #(
	parameter int data_width = 32
) (
	input logic                  clk,
	input logic                  rst_n,
	input logic [data_width-1:0] src1,
	input logic [data_width-1:0] src2,
	input alu_pkg::ctrl_t        alu_control,
	input logic [data_width-1:0] sum_result,	// core output
	input logic                  overflow_next,	// core output
	input logic [data_width-1:0] result,
	input logic                  zero,
	input logic                  cout,
	input logic                  overflow
);

	logic                  is_logic;	// and, or, nor
	logic [data_width-1:0] a_op;
	logic [data_width-1:0] b_op;
	logic [data_width-1:0] add_sum;	// carry-in is zero for these codes
	logic                  ovf_rule;
	logic [data_width-1:0] logic_value;

	assign is_logic = (alu_control == alu_pkg::ctrl_and) || (alu_control == alu_pkg::ctrl_or) ||
		(alu_control == alu_pkg::ctrl_nor);
	assign a_op = src1 ^ {data_width{alu_control[alu_pkg::a_invert_bit]}};
	assign b_op = src2 ^ {data_width{alu_control[alu_pkg::b_invert_bit]}};
	assign add_sum = a_op + b_op;
	assign ovf_rule = (a_op[data_width-1] == b_op[data_width-1]) &&
		(add_sum[data_width-1] != a_op[data_width-1]);
	assign logic_value = (alu_control == alu_pkg::ctrl_or) ? (src1 | src2) :
		(alu_control == alu_pkg::ctrl_nor) ? ~(src1 | src2) : (src1 & src2);

	zero_follows_result: assert property (@(posedge clk) disable iff (!rst_n)
		zero == (result == '0)) else $error("zero flag disagrees with result");

	flags_low_in_reset: assert property (@(posedge clk) !rst_n |-> (!cout && !overflow))
		else $error("cout or overflow high during reset");

	logic_overflow_rule: assert property (@(posedge clk) disable iff (!rst_n)
		is_logic |-> overflow_next == ovf_rule) else $error("overflow off the carry rule");

	logic_result_bitwise: assert property (@(posedge clk) disable iff (!rst_n)
		is_logic |-> sum_result == logic_value) else $error("logic result not bitwise");

endmodule

// ==== bench/alu_checker.sv ====
`timescale 1ns/1ps

module alu_checker #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [data_width-1:0] src1,
	input  logic [data_width-1:0] src2,
	input  alu_pkg::ctrl_t        alu_control,
	input  logic [data_width-1:0] result,
	input  logic                  zero,
	input  logic                  cout,
	input  logic                  overflow,
	input  logic                  file_valid,	// file expectations present
	input  int                    vec_index,
	input  logic [data_width-1:0] exp_result,
	input  logic                  exp_zero,
	input  logic                  exp_cout,
	input  logic                  exp_overflow,
	output int                    error_count
);

	logic                  pending;	// an op was captured on the last edge
	string                 test_name;
	logic [data_width-1:0] m_result;	// model values
	logic                  m_zero, m_cout, m_overflow;
	logic                  f_valid;	// latched file values
	logic [data_width-1:0] f_result;
	logic                  f_zero, f_cout, f_overflow;

	function automatic string op_name(input alu_pkg::ctrl_t ctrl);
		case (ctrl)
			alu_pkg::ctrl_and: return "and";
			alu_pkg::ctrl_or: return "or";
			alu_pkg::ctrl_add: return "add";
			alu_pkg::ctrl_sub: return "sub";
			alu_pkg::ctrl_slt: return "slt";
			alu_pkg::ctrl_nor: return "nor";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input logic [data_width-1:0] exp_v,
		input logic [data_width-1:0] act_v);
		if (exp_v !== act_v) begin
			$display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp_v, act_v);
			error_count++;
		end
	endtask

	////////////////////
	// reference model

	always @(posedge clk) begin
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width:0]   wide;	// sum with carry
		logic                  cin;
		pending <= 1'b0;
		if (rst_n) begin
			a = alu_control[alu_pkg::a_invert_bit] ? ~src1 : src1;
			b = alu_control[alu_pkg::b_invert_bit] ? ~src2 : src2;
			cin = alu_control[alu_pkg::a_invert_bit] ^ alu_control[alu_pkg::b_invert_bit];
			wide = {1'b0, a} + {1'b0, b} + cin;
			m_cout <= wide[data_width];
			m_overflow <= (a[data_width-1] == b[data_width-1]) &&
				(wide[data_width-1] != a[data_width-1]);	// signed overflow
			case (alu_control)
				alu_pkg::ctrl_and: m_result <= src1 & src2;
				alu_pkg::ctrl_or: m_result <= src1 | src2;
				alu_pkg::ctrl_nor: m_result <= ~(src1 | src2);
				alu_pkg::ctrl_slt: m_result <= ($signed(src1) < $signed(src2)) ? 1 : 0;
				default: m_result <= wide[data_width-1:0];	// add and sub
			endcase
			m_zero <= (alu_control == alu_pkg::ctrl_slt) ? !($signed(src1) < $signed(src2)) :
				(alu_control == alu_pkg::ctrl_and) ? ((src1 & src2) == '0) :
				(alu_control == alu_pkg::ctrl_or) ? ((src1 | src2) == '0) :
				(alu_control == alu_pkg::ctrl_nor) ? ((src1 | src2) == '1) :
				(wide[data_width-1:0] == '0);
			test_name <= $sformatf("%s_%0d", op_name(alu_control), vec_index);
			f_valid <= file_valid;
			f_result <= exp_result;
			f_zero <= exp_zero;
			f_cout <= exp_cout;
			f_overflow <= exp_overflow;
			pending <= 1'b1;
		end
	end

	// outputs are stable away from the rising edge
	always @(negedge clk) begin
		if (pending) begin
			compare("result", m_result, result);
			compare("zero", m_zero, zero);
			compare("cout", m_cout, cout);
			compare("overflow", m_overflow, overflow);
			if (f_valid) begin
				compare("file result", f_result, result);
				compare("file zero", f_zero, zero);
				compare("file cout", f_cout, cout);
				compare("file overflow", f_overflow, overflow);
			end
		end
	end

	initial begin
		error_count = 0;
		pending = 1'b0;
		f_valid = 1'b0;
		@(posedge rst_n);
		#1;
		test_name = "reset_release";
		compare("result", '0, result);
		compare("zero", 1, zero);
		compare("cout", 0, cout);
		compare("overflow", 0, overflow);
	end

endmodule

// ==== bench/alu_stimulus.txt ====
# columns: control src1 src2 result zero cout overflow, all hexadecimal
# control 0 and, 1 or, 2 add, 6 sub, 7 slt, c nor
0 ffffffff 0000ffff 0000ffff 0 1 0
0 ff00ff00 00ff00ff 00000000 1 0 0
0 80000000 80000000 80000000 0 1 1
1 12340000 00005678 12345678 0 0 0
1 00000000 00000000 00000000 1 0 0
1 7fffffff 00000001 7fffffff 0 0 1
2 00000001 00000002 00000003 0 0 0
2 7fffffff 00000001 80000000 0 0 1
2 ffffffff 00000001 00000000 1 1 0
2 80000000 80000000 00000000 1 1 1
2 deadbeef 12345678 f0e21567 0 0 0
6 00000005 00000003 00000002 0 1 0
6 00000003 00000005 fffffffe 0 0 0
6 12345678 12345678 00000000 1 1 0
6 80000000 00000001 7fffffff 0 1 1
6 00000000 00000001 ffffffff 0 0 0
6 7fffffff ffffffff 80000000 0 0 1
7 00000001 00000002 00000001 0 0 0
7 00000002 00000001 00000000 1 1 0
7 ffffffff 00000001 00000001 0 1 0
7 80000000 00000001 00000001 0 1 1
7 7fffffff ffffffff 00000000 1 0 1
7 00000004 00000004 00000000 1 1 0
c 00000000 00000000 ffffffff 0 1 0
c ffffffff 00000000 00000000 1 0 0
c f0f0f0f0 0f0f0f00 0000000f 0 1 0
c 7fffffff 7fffffff 80000000 0 1 1
2 00000000 00000000 00000000 1 0 0
6 00000000 00000000 00000000 1 1 0
1 f0000000 0000000f f000000f 0 0 0

// ==== bench/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;

	localparam int data_width = alu_pkg::data_width;
	localparam int random_count = 200;	// vectors after the file
	localparam int max_lines = 1000;	// stimulus file line limit
	localparam int max_cycles = 5000;	// whole-run limit

	logic                  clk;
	logic                  rst_n;
	logic [data_width-1:0] src1;
	logic [data_width-1:0] src2;
	alu_pkg::ctrl_t        alu_control;
	logic [data_width-1:0] result;
	logic                  zero;
	logic                  cout;
	logic                  overflow;

	// expected values from the stimulus file
	logic                  file_valid;
	int                    vec_index;
	logic [data_width-1:0] exp_result;
	logic                  exp_zero;
	logic                  exp_cout;
	logic                  exp_overflow;

	int check_errors;	// from the checker
	int other_errors;	// file and timeout trouble
	logic [31:0] lcg_state;

	alu_pkg::ctrl_t op_codes [6] = '{alu_pkg::ctrl_and, alu_pkg::ctrl_or, alu_pkg::ctrl_add,
		alu_pkg::ctrl_sub, alu_pkg::ctrl_slt, alu_pkg::ctrl_nor};

	alu #(.data_width(data_width)) UUT (
		.clk(clk), .rst_n(rst_n), .src1(src1), .src2(src2), .alu_control(alu_control),
		.result(result), .zero(zero), .cout(cout), .overflow(overflow)
	);

	alu_checker #(.data_width(data_width)) u_checker (
		.clk(clk), .rst_n(rst_n), .src1(src1), .src2(src2), .alu_control(alu_control),
		.result(result), .zero(zero), .cout(cout), .overflow(overflow),
		.file_valid(file_valid), .vec_index(vec_index), .exp_result(exp_result),
		.exp_zero(exp_zero), .exp_cout(exp_cout), .exp_overflow(exp_overflow),
		.error_count(check_errors)
	);

	bind alu alu_assertions #(.data_width(data_width)) u_assertions (
		.clk(clk), .rst_n(rst_n), .src1(src1), .src2(src2), .alu_control(alu_control),
		.sum_result(sum_result), .overflow_next(overflow_next), .result(result),
		.zero(zero), .cout(cout), .overflow(overflow)
	);

	// numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	////////////////////
	// run limit

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("simulation did not finish within %0d cycles", max_cycles);
		$display("Finished with errors");
		$finish;
	end

	task automatic drive(input alu_pkg::ctrl_t ctrl, input logic [data_width-1:0] a,
		input logic [data_width-1:0] b);
		@(negedge clk);
		alu_control = ctrl;
		src1 = a;
		src2 = b;
	endtask

	task automatic run_file_vectors;
		int fd;
		int lines;
		int fields;
		string line;
		logic [31:0] f_ctrl, f_a, f_b, f_r, f_z, f_c, f_o;
		fd = $fopen("bench/alu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file bench/alu_stimulus.txt");
			other_errors++;
			return;
		end
		lines = 0;
		while (!$feof(fd) && lines < max_lines) begin
			lines++;
			if ($fgets(line, fd) == 0) continue;
			if (line.len() == 0 || line[0] == "#") continue;	// column header
			fields = $sscanf(line, "%h %h %h %h %h %h %h", f_ctrl, f_a, f_b, f_r, f_z, f_c, f_o);
			if (fields != 7) continue;	// blank line
			@(negedge clk);
			alu_control = f_ctrl[alu_pkg::ctrl_width-1:0];
			src1 = f_a;
			src2 = f_b;
			file_valid = 1'b1;
			exp_result = f_r;
			exp_zero = f_z[0];
			exp_cout = f_c[0];
			exp_overflow = f_o[0];
			vec_index++;
		end
		if (lines >= max_lines) begin
			$display("stimulus file did not end within %0d lines", max_lines);
			other_errors++;
		end
		$fclose(fd);
	endtask

	////////////////////
	// main sequence

	initial begin
		rst_n = 1'b0;
		src1 = '0;
		src2 = '0;
		alu_control = alu_pkg::ctrl_and;
		file_valid = 1'b0;
		vec_index = 0;
		exp_result = '0;
		exp_zero = 1'b0;
		exp_cout = 1'b0;
		exp_overflow = 1'b0;
		other_errors = 0;
		lcg_state = 32'hdc5a_a9f8;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;	// released on a falling edge
		run_file_vectors();
		@(negedge clk);
		file_valid = 1'b0;	// random part, checker model only
		for (int i = 0; i < random_count; i++) begin
			logic [31:0] a;
			logic [31:0] b;
			lcg_state = lcg_next(lcg_state);
			a = lcg_state;
			lcg_state = lcg_next(lcg_state);
			b = (lcg_state[3:0] == 4'd0) ? a : lcg_state;	// some equal pairs
			lcg_state = lcg_next(lcg_state);
			drive(op_codes[lcg_state[31:16] % 6], a, b);
			vec_index++;
		end
		repeat (3) @(posedge clk);	// let the last compare settle
		$display("errors: %0d check, %0d other", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/alu_pkg.sv
hdl/alu_bit_slice.sv
hdl/alu_msb_slice.sv
hdl/alu_ripple_core.sv
hdl/alu_result_register.sv
hdl/alu.sv
bench/alu_assertions.sv
bench/alu_checker.sv
bench/alu_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu #(
	parameter int data_width = alu_pkg::data_width	// operand width
) (
	input  logic                  clk,
	input  logic                  rst_n,	// async, active low
	input  logic [data_width-1:0] src1,	// operand a, sampled each edge
	input  logic [data_width-1:0] src2,	// operand b, sampled each edge
	input  alu_pkg::ctrl_t        alu_control,	// operation code
	output logic [data_width-1:0] result,	// one cycle after the inputs
	output logic                  zero,	// result is all zeros
	output logic                  cout,	// adder carry out
	output logic                  overflow	// signed overflow
);

	logic [data_width-1:0] sum_result;	// core to register
	logic                  carry_out;	// core to register
	logic                  overflow_next;	// core to register

	////////////////////
	// combinational datapath

	alu_ripple_core #(
		.data_width (data_width)
	) u_core (
		.src1          (src1),
		.src2          (src2),
		.alu_control   (alu_control),
		.sum_result    (sum_result),
		.carry_out     (carry_out),
		.overflow_next (overflow_next)
	);

	////////////////////
	// output stage

	alu_result_register #(
		.data_width (data_width)
	) u_reg (
		.clk           (clk),
		.rst_n         (rst_n),
		.sum_result    (sum_result),
		.carry_out     (carry_out),
		.overflow_next (overflow_next),
		.result        (result),
		.zero          (zero),
		.cout          (cout),
		.overflow      (overflow)
	);

endmodule

// ==== hdl/alu_bit_slice.sv ====
`timescale 1ns/1ps

module alu_bit_slice (
	input  logic                         src1,	// operand a bit
	input  logic                         src2,	// operand b bit
	input  logic                         less,	// set value, bit 0 only
	input  logic                         a_invert,	// invert a
	input  logic                         b_invert,	// invert b
	input  logic                         cin,	// carry from lower bit
	input  logic [alu_pkg::op_width-1:0] operation,	// slice op select
	output logic                         result,	// selected bit
	output logic                         cout	// carry to upper bit
);

	logic a_bit;	// a after optional inversion
	logic b_bit;	// b after optional inversion
	logic sum;	// full adder sum

	assign a_bit = src1 ^ a_invert;
	assign b_bit = src2 ^ b_invert;

	// full adder
	assign sum = a_bit ^ b_bit ^ cin;
	assign cout = (a_bit & b_bit) | (a_bit & cin) | (b_bit & cin);	// majority

	// output mux, nor falls out of and with both inputs inverted
	always_comb begin
		case (operation)
			alu_pkg::op_and: begin
				result = a_bit & b_bit;
			end
			alu_pkg::op_or: begin
				result = a_bit | b_bit;
			end
			alu_pkg::op_add: begin
				result = sum;
			end
			default: begin
				result = less;	// op_less
			end
		endcase
	end

endmodule

// ==== hdl/alu_msb_slice.sv ====
`timescale 1ns/1ps

module alu_msb_slice (
	input  logic                         src1,	// operand a sign bit
	input  logic                         src2,	// operand b sign bit
	input  logic                         less,	// tied low by the core
	input  logic                         a_invert,	// invert a
	input  logic                         b_invert,	// invert b
	input  logic                         cin,	// carry into the top bit
	input  logic [alu_pkg::op_width-1:0] operation,	// slice op select
	output logic                         result,	// selected bit
	output logic                         cout,	// carry out of the top bit
	output logic                         set_less,	// signed a < b
	output logic                         overflow	// signed overflow
);

	logic a_bit;	// a after optional inversion
	logic b_bit;	// b after optional inversion
	logic sum;	// top bit of the adder

	assign a_bit = src1 ^ a_invert;
	assign b_bit = src2 ^ b_invert;

	////////////////////
	// adder

	assign sum = a_bit ^ b_bit ^ cin;
	assign cout = (a_bit & b_bit) | (a_bit & cin) | (b_bit & cin);

	// carries into and out of the sign bit disagree on overflow
	assign overflow = cin ^ cout;

	// sign of a - b, corrected when the difference overflowed
	assign set_less = sum ^ overflow;

	////////////////////
	// result select

	always_comb begin
		case (operation)
			alu_pkg::op_and: begin
				result = a_bit & b_bit;
			end
			alu_pkg::op_or: begin
				result = a_bit | b_bit;
			end
			alu_pkg::op_add: begin
				result = sum;
			end
			default: begin
				result = less;	// slt upper bits read zero
			end
		endcase
	end

endmodule

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

	////////////////////
	// widths

	localparam int data_width = 32;	// default operand width
	localparam int ctrl_width = 4;	// alu_control width

	typedef logic [ctrl_width-1:0] ctrl_t;	// full control word

	////////////////////
	// control word fields

	localparam int a_invert_bit = 3;	// invert src1 before the slice
	localparam int b_invert_bit = 2;	// invert src2 before the slice
	localparam int op_lsb = 0;	// low bit of the slice op field
	localparam int op_width = 2;	// slice op field width

	// slice operation select
	localparam logic [op_width-1:0] op_and = 2'd0;	// a & b
	localparam logic [op_width-1:0] op_or = 2'd1;	// a | b
	localparam logic [op_width-1:0] op_add = 2'd2;	// full adder sum
	localparam logic [op_width-1:0] op_less = 2'd3;	// pass less input

	////////////////////
	// full control codes

	localparam ctrl_t ctrl_and = 4'b0000;	// bitwise and
	localparam ctrl_t ctrl_or = 4'b0001;	// bitwise or
	localparam ctrl_t ctrl_add = 4'b0010;	// a + b
	localparam ctrl_t ctrl_sub = 4'b0110;	// a + ~b + 1
	localparam ctrl_t ctrl_slt = 4'b0111;	// signed a < b
	localparam ctrl_t ctrl_nor = 4'b1100;	// ~a & ~b, i.e. nor

	// other codes are outside the contract, the slices still
	// decode them through the fields above without any special case

endpackage

// ==== hdl/alu_result_register.sv ====
`timescale 1ns/1ps

module alu_result_register #(
	parameter int data_width = 32	// result width
) (
	input  logic                  clk,
	input  logic                  rst_n,	// async, active low
	input  logic [data_width-1:0] sum_result,	// from the ripple core
	input  logic                  carry_out,	// adder carry of the top bit
	input  logic                  overflow_next,	// signed overflow
	output logic [data_width-1:0] result,	// registered result
	output logic                  zero,	// result is all zeros
	output logic                  cout,	// registered carry
	output logic                  overflow	// registered overflow
);

	logic zero_next;	// flag for the value being captured

	// taken from the incoming result so the flag lines up with it
	assign zero_next = ~|sum_result;

	////////////////////
	// output registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			zero <= 1'b1;	// matches the cleared result
			cout <= 1'b0;
			overflow <= 1'b0;
		end else begin
			result <= sum_result;	// new op every cycle
			zero <= zero_next;
			cout <= carry_out;
			overflow <= overflow_next;
		end
	end

	// all four outputs move on the same edge
	// so result and flags always belong to one operation

	// carry and overflow are captured for every op, logic ops included
	// their values then follow the adder rule on the inverted operands

endmodule

// ==== hdl/alu_ripple_core.sv ====
`timescale 1ns/1ps

module alu_ripple_core #(
	parameter int data_width = 32	// operand width, at least 2
) (
	input  logic [data_width-1:0] src1,	// operand a
	input  logic [data_width-1:0] src2,	// operand b
	input  alu_pkg::ctrl_t        alu_control,	// invert bits and slice op
	output logic [data_width-1:0] sum_result,	// combinational result
	output logic                  carry_out,	// carry out of the top bit
	output logic                  overflow_next	// signed overflow
);

	logic                         a_invert;	// from control word
	logic                         b_invert;	// from control word
	logic [alu_pkg::op_width-1:0] operation;	// slice op field
	logic                         carry_in;	// carry into bit 0
	logic                         set_less;	// from msb slice back to bit 0

	////////////////////
	// control decode

	assign a_invert = alu_control[alu_pkg::a_invert_bit];
	assign b_invert = alu_control[alu_pkg::b_invert_bit];
	assign operation = alu_control[alu_pkg::op_lsb +: alu_pkg::op_width];

	// sub inverts b alone, so it needs the +1 of two's complement
	// nor inverts both and the carry-in stays low
	assign carry_in = a_invert ^ b_invert;

	////////////////////
	// lower slices

	for (genvar i = 0; i < data_width - 1; i++) begin : g_slice
		logic cin;	// carry into this bit
		logic carry;	// carry out of this bit
		logic less;	// slt value for this bit

		if (i == 0) begin : g_first
			assign cin = carry_in;
			assign less = set_less;	// only bit 0 carries the slt answer
		end else begin : g_chain
			assign cin = g_slice[i-1].carry;	// ripple
			assign less = 1'b0;
		end

		alu_bit_slice u_slice (
			.src1      (src1[i]),
			.src2      (src2[i]),
			.less      (less),
			.a_invert  (a_invert),
			.b_invert  (b_invert),
			.cin       (cin),
			.operation (operation),
			.result    (sum_result[i]),
			.cout      (carry)
		);
	end

	////////////////////
	// sign bit

	alu_msb_slice u_msb (
		.src1      (src1[data_width-1]),
		.src2      (src2[data_width-1]),
		.less      (1'b0),
		.a_invert  (a_invert),
		.b_invert  (b_invert),
		.cin       (g_slice[data_width-2].carry),	// top of the chain
		.operation (operation),
		.result    (sum_result[data_width-1]),
		.cout      (carry_out),
		.set_less  (set_less),
		.overflow  (overflow_next)
	);

endmodule
